//--- Bender.yml
package:
  name: sdram_controller

sources:
  # shared package first
  - common/sdram_pkg.sv
  # design
  - initializer/sdram_initializer.sv
  - logic/sdram_refresh_timer.sv
  - logic/sdram_row_tracker.sv
  - logic/sdram_command_sequencer.sv
  - logic/sdram_controller_top.sv
  # testbench
  - target: test
    files:
      - testbench/tb_sdram_controller.sv

//--- common/sdram_pkg.sv
package sdram_pkg;

	// command pin encoding is {ras, cas, we}, all active low
	typedef enum logic [2:0]
	{
		cmd_mrs   = 3'b000, // mode register set
		cmd_ref   = 3'b001, // auto refresh
		cmd_pre   = 3'b010, // precharge, row close
		cmd_act   = 3'b011, // activate, row open
		cmd_write = 3'b100,
		cmd_read  = 3'b101,
		cmd_bst   = 3'b110, // burst terminate
		cmd_nop   = 3'b111
	} sdram_cmd_e;

	// each command state is the cycle its command sits on the pins
	typedef enum logic [2:0]
	{
		st_idle,
		st_precharge,   // bank precharge for a row miss
		st_activate,
		st_access,      // read or write, ack high
		st_refresh_pre, // precharge all ahead of refresh
		st_refresh,
		st_wait         // nop cycles on the shared counter
	} seq_state_e;

	// linear user address is {bank, row, col}
	localparam int row_w  = 13;
	localparam int col_w  = 9;
	localparam int bank_w = 2;
	localparam int addr_w = bank_w + row_w + col_w; // 24

	// address pin bit that selects all banks on precharge
	localparam int ap_bit = 10;

endpackage

//--- initializer/sdram_initializer.sv
`timescale 1ns/1ps

module sdram_initializer #(
	parameter int power_wait  = 200,
	parameter int cmd_gap     = 15,
	parameter int settle_wait = 255
) (
	input  logic                   CLK_n,
	input  logic                   RST,
	input  sdram_pkg::sdram_cmd_e  seq_cmd,
	input  logic [12:0]            seq_addr,
	input  logic [1:0]             seq_bank,
	output logic                   cke,
	output sdram_pkg::sdram_cmd_e  cmd_pin,
	output logic [12:0]            addr_pin,
	output logic [1:0]             bank_pin,
	output logic                   user_ready
);
	import sdram_pkg::*;

	localparam int table_len = 7;
	localparam int wait_max  = (power_wait > cmd_gap) ?
		((power_wait > settle_wait) ? power_wait : settle_wait) :
		((cmd_gap > settle_wait) ? cmd_gap : settle_wait);
	localparam int cnt_w = $clog2(wait_max + 1);
	localparam logic [12:0] all_banks = 13'(1) << ap_bit;

	logic [cnt_w-1:0] cnt;   // power-up, gap and settle counter
	logic [2:0]       stage; // next table entry
	sdram_cmd_e       ini_cmd;
	logic [12:0]      ini_addr;
	logic [1:0]       ini_bank;
	sdram_cmd_e       rom_cmd;
	logic [12:0]      rom_addr;
	logic [1:0]       rom_bank;

	always_comb
	begin
		rom_addr = all_banks;
		rom_bank = 2'd0;
		case (stage)
			3'd0: begin rom_cmd = cmd_pre; rom_bank = 2'd1; end
			3'd1: begin rom_cmd = cmd_mrs; rom_addr = 13'h000; rom_bank = 2'd1; end // extended mode
			3'd2: begin rom_cmd = cmd_mrs; rom_addr = 13'h162; end // dll reset
			3'd3: rom_cmd = cmd_pre;
			3'd4: rom_cmd = cmd_ref;
			3'd5: rom_cmd = cmd_ref;
			3'd6: begin rom_cmd = cmd_mrs; rom_addr = 13'h062; end // final mode
			default: rom_cmd = cmd_nop;
		endcase
	end

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			cke        <= 1'b0;
			user_ready <= 1'b0;
			stage      <= 3'd0;
			cnt        <= '0;
			ini_cmd    <= cmd_nop;
		end
		else
		begin
			ini_cmd <= cmd_nop;
			if (!cke)
			begin
				if (cnt == cnt_w'(power_wait - 1))
				begin
					cke <= 1'b1;
					cnt <= '0;
				end
				else
					cnt <= cnt + 1'b1;
			end
			else if (stage != 3'(table_len))
			begin
				if (cnt == '0)
				begin
					ini_cmd  <= rom_cmd;
					ini_addr <= rom_addr;
					ini_bank <= rom_bank;
					stage    <= stage + 1'b1;
					// last entry is followed by the settle wait
					cnt <= (stage == 3'(table_len - 1)) ? cnt_w'(settle_wait) : cnt_w'(cmd_gap);
				end
				else
					cnt <= cnt - 1'b1;
			end
			else if (!user_ready)
			begin
				if (cnt == '0)
					user_ready <= 1'b1; // stays up until reset
				else
					cnt <= cnt - 1'b1;
			end
		end
	end

	// sequencer owns the pins once init is done
	assign cmd_pin  = user_ready ? seq_cmd  : ini_cmd;
	assign addr_pin = user_ready ? seq_addr : ini_addr;
	assign bank_pin = user_ready ? seq_bank : ini_bank;

	a_nop_while_cke_low: assert property (@(posedge CLK_n) disable iff (!RST)
		!cke |-> cmd_pin == cmd_nop);

endmodule

//--- logic/sdram_command_sequencer.sv
`timescale 1ns/1ps

module sdram_command_sequencer #(
	parameter int t_rp  = 3,
	parameter int t_rcd = 3,
	parameter int t_rfc = 10
) (
	input  logic                           CLK_n,
	input  logic                           RST,
	input  logic                           user_ready,
	input  logic                           req,
	input  logic                           we,
	output logic                           ack,
	input  logic                           refresh_due,
	output logic                           refresh_ack,
	input  logic                           row_hit,
	input  logic                           row_miss,
	input  logic                           bank_empty,
	input  logic                           any_open,
	input  logic [sdram_pkg::bank_w-1:0]   req_bank,
	input  logic [sdram_pkg::row_w-1:0]    req_row,
	input  logic [sdram_pkg::col_w-1:0]    req_col,
	output logic                           open_row,
	output logic                           close_bank,
	output logic                           close_all,
	output sdram_pkg::sdram_cmd_e          seq_cmd,
	output logic [12:0]                    seq_addr,
	output logic [1:0]                     seq_bank
);
	import sdram_pkg::*;

	localparam int wait_max = (t_rp > t_rcd) ?
		((t_rp > t_rfc) ? t_rp : t_rfc) :
		((t_rcd > t_rfc) ? t_rcd : t_rfc);
	localparam int cnt_w = $clog2(wait_max + 1);

	seq_state_e       state;
	seq_state_e       target; // state entered at the next edge
	seq_state_e       resume; // step after the current wait
	logic [cnt_w-1:0] cnt;
	logic [12:0]      col_addr;

	// column on the address pins with auto precharge off
	assign col_addr = 13'(req_col) & ~(13'(1) << ap_bit);

	always_comb
	begin
		target = state;
		case (state)
			st_idle:
			begin
				if (user_ready && refresh_due)
					target = any_open ? st_refresh_pre : st_refresh; // refresh wins
				else if (user_ready && req)
				begin
					if (row_hit)
						target = st_access;
					else if (bank_empty)
						target = st_activate;
					else if (row_miss)
						target = st_precharge;
				end
			end
			st_access:
				target = st_idle;
			default: // command and wait states share the counter
				target = (cnt == '0) ? resume : st_wait;
		endcase
	end

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			state       <= st_idle;
			resume      <= st_idle;
			cnt         <= '0;
			seq_cmd     <= cmd_nop;
			ack         <= 1'b0;
			refresh_ack <= 1'b0;
			open_row    <= 1'b0;
			close_bank  <= 1'b0;
			close_all   <= 1'b0;
		end
		else
		begin
			state       <= target;
			seq_cmd     <= cmd_nop;
			ack         <= 1'b0;
			refresh_ack <= 1'b0;
			open_row    <= 1'b0;
			close_bank  <= 1'b0;
			close_all   <= 1'b0;
			case (target)
				st_precharge:
				begin
					seq_cmd    <= cmd_pre;
					seq_addr   <= 13'h000; // one bank with ap low
					seq_bank   <= req_bank;
					close_bank <= 1'b1;
					cnt        <= cnt_w'(t_rp);
					resume     <= st_activate;
				end
				st_activate:
				begin
					seq_cmd  <= cmd_act;
					seq_addr <= req_row;
					seq_bank <= req_bank;
					open_row <= 1'b1;
					cnt      <= cnt_w'(t_rcd);
					resume   <= st_access;
				end
				st_access:
				begin
					seq_cmd  <= we ? cmd_write : cmd_read;
					seq_addr <= col_addr;
					seq_bank <= req_bank;
					ack      <= 1'b1;
				end
				st_refresh_pre:
				begin
					seq_cmd   <= cmd_pre;
					seq_addr  <= 13'(1) << ap_bit; // all banks
					seq_bank  <= 2'd0;
					close_all <= 1'b1;
					cnt       <= cnt_w'(t_rp);
					resume    <= st_refresh;
				end
				st_refresh:
				begin
					seq_cmd     <= cmd_ref;
					refresh_ack <= 1'b1;
					cnt         <= cnt_w'(t_rfc);
					resume      <= st_idle;
				end
				st_wait:
					cnt <= cnt - 1'b1;
				default:
					;
			endcase
		end
	end

	a_ack_with_access: assert property (@(posedge CLK_n) disable iff (!RST)
		ack |-> (seq_cmd == cmd_read || seq_cmd == cmd_write));

endmodule

//--- logic/sdram_controller_top.sv
`timescale 1ns/1ps

module sdram_controller_top #(
	parameter int power_wait       = 200,
	parameter int cmd_gap          = 15,
	parameter int settle_wait      = 255,
	parameter int refresh_interval = 1560,
	parameter int t_rp             = 3,
	parameter int t_rcd            = 3,
	parameter int t_rfc            = 10
) (
	input  logic                           CLK_n,
	input  logic                           RST,
	input  logic                           req,
	input  logic                           we,
	input  logic [sdram_pkg::addr_w-1:0]   addr,
	output logic                           ack,
	output logic                           user_ready,
	output logic                           cke,
	output sdram_pkg::sdram_cmd_e          cmd_pin,
	output logic [12:0]                    addr_pin,
	output logic [1:0]                     bank_pin
);
	import sdram_pkg::*;

	sdram_cmd_e        seq_cmd;
	logic [12:0]       seq_addr;
	logic [1:0]        seq_bank;
	logic              refresh_due;
	logic              refresh_ack;
	logic [bank_w-1:0] req_bank;
	logic [row_w-1:0]  req_row;
	logic [col_w-1:0]  req_col;
	logic              row_hit;
	logic              row_miss;
	logic              bank_empty;
	logic              any_open;
	logic              open_row;
	logic              close_bank;
	logic              close_all;

	sdram_initializer #(
		.power_wait  (power_wait),
		.cmd_gap     (cmd_gap),
		.settle_wait (settle_wait)
	) u_initializer (
		.CLK_n      (CLK_n),
		.RST        (RST),
		.seq_cmd    (seq_cmd),
		.seq_addr   (seq_addr),
		.seq_bank   (seq_bank),
		.cke        (cke),
		.cmd_pin    (cmd_pin),
		.addr_pin   (addr_pin),
		.bank_pin   (bank_pin),
		.user_ready (user_ready)
	);

	sdram_refresh_timer #(
		.refresh_interval (refresh_interval)
	) u_refresh_timer (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.enable      (user_ready),
		.refresh_ack (refresh_ack),
		.refresh_due (refresh_due)
	);

	sdram_row_tracker u_row_tracker (
		.CLK_n      (CLK_n),
		.RST        (RST),
		.addr       (addr),
		.open_row   (open_row),
		.close_bank (close_bank),
		.close_all  (close_all),
		.req_bank   (req_bank),
		.req_row    (req_row),
		.req_col    (req_col),
		.row_hit    (row_hit),
		.row_miss   (row_miss),
		.bank_empty (bank_empty),
		.any_open   (any_open)
	);

	sdram_command_sequencer #(
		.t_rp  (t_rp),
		.t_rcd (t_rcd),
		.t_rfc (t_rfc)
	) u_sequencer (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.user_ready  (user_ready),
		.req         (req),
		.we          (we),
		.ack         (ack),
		.refresh_due (refresh_due),
		.refresh_ack (refresh_ack),
		.row_hit     (row_hit),
		.row_miss    (row_miss),
		.bank_empty  (bank_empty),
		.any_open    (any_open),
		.req_bank    (req_bank),
		.req_row     (req_row),
		.req_col     (req_col),
		.open_row    (open_row),
		.close_bank  (close_bank),
		.close_all   (close_all),
		.seq_cmd     (seq_cmd),
		.seq_addr    (seq_addr),
		.seq_bank    (seq_bank)
	);

endmodule

//--- logic/sdram_refresh_timer.sv
`timescale 1ns/1ps

module sdram_refresh_timer #(
	parameter int refresh_interval = 1560
) (
	input  logic CLK_n,
	input  logic RST,
	input  logic enable,
	input  logic refresh_ack,
	output logic refresh_due
);

	localparam int cnt_w = $clog2(refresh_interval + 1);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			cnt         <= cnt_w'(refresh_interval);
			refresh_due <= 1'b0;
		end
		else if (refresh_ack)
		begin
			cnt         <= cnt_w'(refresh_interval); // restart interval
			refresh_due <= 1'b0;
		end
		else if (enable)
		begin
			if (cnt == '0)
				refresh_due <= 1'b1; // held until ack
			else
				cnt <= cnt - 1'b1;
		end
	end

	// the sequencer only acks a pending refresh
	a_ack_needs_due: assert property (@(posedge CLK_n) disable iff (!RST)
		refresh_ack |-> refresh_due);

endmodule

//--- logic/sdram_row_tracker.sv
`timescale 1ns/1ps

module sdram_row_tracker (
	input  logic                           CLK_n,
	input  logic                           RST,
	input  logic [sdram_pkg::addr_w-1:0]   addr,
	input  logic                           open_row,
	input  logic                           close_bank,
	input  logic                           close_all,
	output logic [sdram_pkg::bank_w-1:0]   req_bank,
	output logic [sdram_pkg::row_w-1:0]    req_row,
	output logic [sdram_pkg::col_w-1:0]    req_col,
	output logic                           row_hit,
	output logic                           row_miss,
	output logic                           bank_empty,
	output logic                           any_open
);
	import sdram_pkg::*;

	localparam int num_banks = 1 << bank_w;

	logic [num_banks-1:0] open_flag;
	logic [row_w-1:0]     open_rows [num_banks];

	// split from the top: bank, row, column
	assign req_bank = addr[addr_w-1 -: bank_w];
	assign req_row  = addr[col_w +: row_w];
	assign req_col  = addr[col_w-1:0];

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
			open_flag <= '0;
		else if (close_all)
			open_flag <= '0;
		else if (open_row)
			open_flag[req_bank] <= 1'b1;
		else if (close_bank)
			open_flag[req_bank] <= 1'b0;
	end

	always_ff @(posedge CLK_n)
	begin
		if (open_row)
			open_rows[req_bank] <= req_row;
	end

	assign bank_empty = !open_flag[req_bank];
	assign row_hit    = open_flag[req_bank] && (open_rows[req_bank] == req_row);
	assign row_miss   = open_flag[req_bank] && (open_rows[req_bank] != req_row);
	assign any_open   = |open_flag;

	a_one_decision: assert property (@(posedge CLK_n) disable iff (!RST)
		$onehot({row_hit, row_miss, bank_empty}));

endmodule

//--- sources.f
common/sdram_pkg.sv
initializer/sdram_initializer.sv
logic/sdram_refresh_timer.sv
logic/sdram_row_tracker.sv
logic/sdram_command_sequencer.sv
logic/sdram_controller_top.sv
testbench/tb_sdram_controller.sv

//--- testbench/sdram_patterns.mem
// columns: write flag (1 hex digit), linear address {bank, row, col} (6 hex digits),
// idle cycles before the request (2 hex digits)
1_000a10_03
0_000a22_01
1_403e03_05
0_000c01_02
0_403fff_04
1_b57855_08
1_c00100_01
0_c00204_06
0_b578aa_3c
1_000c20_02
0_404000_07
1_c003fe_01
0_3ffe00_0a
1_b57a01_05
0_3fff23_02
1_4040ff_50

//--- testbench/tb_sdram_controller.sv
`timescale 1ns/1ps

module tb_sdram_controller;
	import sdram_pkg::*;

	localparam int power_wait       = 20;
	localparam int cmd_gap          = 4;
	localparam int settle_wait      = 10;
	localparam int refresh_interval = 150;
	localparam int t_rp             = 2;
	localparam int t_rcd            = 2;
	localparam int t_rfc            = 6;
	localparam int num_pat          = 16;

	logic              CLK_n;
	logic              RST;
	logic              req;
	logic              we;
	logic [addr_w-1:0] addr;
	logic              ack;
	logic              user_ready;
	logic              cke;
	sdram_cmd_e        cmd_pin;
	logic [12:0]       addr_pin;
	logic [1:0]        bank_pin;

	logic [35:0]      patterns [num_pat]; // {we, addr, gap}
	sdram_cmd_e       obs_cmd [$];        // non-nop pin commands in order
	logic [12:0]      obs_addr [$];
	logic [1:0]       obs_bank [$];
	time              obs_time [$];
	int               obs_cycle [$];
	int               rd;
	int               cycle;
	int               limit;
	int               ack_count;
	int               refresh_count;
	int               pre_all_count;
	bit               ready_seen;
	logic [3:0]       model_open;         // banks the model thinks are open
	logic [row_w-1:0] model_row [4];

	sdram_controller_top #(
		.power_wait       (power_wait),
		.cmd_gap          (cmd_gap),
		.settle_wait      (settle_wait),
		.refresh_interval (refresh_interval),
		.t_rp             (t_rp),
		.t_rcd            (t_rcd),
		.t_rfc            (t_rfc)
	) u_sdram_controller_top (
		.CLK_n      (CLK_n),
		.RST        (RST),
		.req        (req),
		.we         (we),
		.addr       (addr),
		.ack        (ack),
		.user_ready (user_ready),
		.cke        (cke),
		.cmd_pin    (cmd_pin),
		.addr_pin   (addr_pin),
		.bank_pin   (bank_pin)
	);

	initial
		CLK_n = 1'b0;
	always #5 CLK_n = ~CLK_n;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// {cmd, addr, bank} of each power-up table entry
	function automatic logic [17:0] init_entry(input int i);
		case (i)
			0: init_entry = {cmd_pre, 13'h400, 2'd1};
			1: init_entry = {cmd_mrs, 13'h000, 2'd1};
			2: init_entry = {cmd_mrs, 13'h162, 2'd0};
			3: init_entry = {cmd_pre, 13'h400, 2'd0};
			4, 5: init_entry = {cmd_ref, 13'h000, 2'd0};
			default: init_entry = {cmd_mrs, 13'h062, 2'd0};
		endcase
	endfunction

	task automatic expect_cmd(input sdram_cmd_e exp_cmd, input logic [12:0] exp_addr,
		input logic [12:0] addr_mask, input logic [1:0] exp_bank, input bit check_bank);
		sdram_cmd_e got;
		assert (rd < obs_cmd.size())
		else
			stop_with_error($sformatf("command %s never appeared on the pins (checked at %0t)",
				exp_cmd.name(), $time));
		got = obs_cmd[rd];
		assert (got == exp_cmd)
		else
			stop_with_error($sformatf("[ERROR] %0t cmd_pin: expected %s, got %s",
				obs_time[rd], exp_cmd.name(), got.name()));
		assert ((obs_addr[rd] & addr_mask) == (exp_addr & addr_mask))
		else
			stop_with_error($sformatf("[ERROR] %0t addr_pin: expected %h, got %h (mask %h)",
				obs_time[rd], exp_addr, obs_addr[rd], addr_mask));
		assert (!check_bank || obs_bank[rd] == exp_bank)
		else
			stop_with_error($sformatf("[ERROR] %0t bank_pin: expected %0d, got %0d",
				obs_time[rd], exp_bank, obs_bank[rd]));
		rd++;
	endtask

	task automatic check_init_table();
		logic [17:0] e;
		logic [12:0] mask;
		assert (obs_cmd.size() == 7)
		else
			stop_with_error($sformatf("user_ready rose after %0d init commands instead of 7",
				obs_cmd.size()));
		rd = 0;
		for (int i = 0; i < 7; i++)
		begin
			e    = init_entry(i);
			mask = (e[17:15] == cmd_ref) ? 13'h0000 : 13'h1fff; // refresh ignores addr
			if (i > 0)
				assert (obs_cycle[i] - obs_cycle[i-1] == cmd_gap + 1)
				else
					stop_with_error($sformatf("[ERROR] %0t cmd_pin: spacing expected %0d, got %0d",
						obs_time[i], cmd_gap + 1, obs_cycle[i] - obs_cycle[i-1]));
			expect_cmd(sdram_cmd_e'(e[17:15]), e[14:2], mask, e[1:0], e[17:15] != cmd_ref);
		end
	endtask

	// open-page model: refreshes first, then precharge on miss, activate, access
	task automatic check_request(input logic wr, input logic [addr_w-1:0] a);
		logic [bank_w-1:0] bank;
		logic [row_w-1:0]  row;
		logic [col_w-1:0]  col;
		bank = a[addr_w-1 -: bank_w];
		row  = a[col_w +: row_w];
		col  = a[col_w-1:0];
		while (rd < obs_cmd.size() && (obs_cmd[rd] == cmd_ref ||
			(obs_cmd[rd] == cmd_pre && obs_addr[rd][ap_bit])))
		begin
			if (model_open != '0)
			begin
				expect_cmd(cmd_pre, 13'h400, 13'h400, 2'd0, 1'b0); // all banks
				pre_all_count++;
			end
			expect_cmd(cmd_ref, 13'h000, 13'h000, 2'd0, 1'b0);
			model_open = '0;
			refresh_count++;
		end
		if (model_open[bank] && model_row[bank] != row)
		begin
			expect_cmd(cmd_pre, 13'h000, 13'h400, bank, 1'b1); // single bank, ap low
			model_open[bank] = 1'b0;
		end
		if (!model_open[bank])
		begin
			expect_cmd(cmd_act, 13'(row), 13'h1fff, bank, 1'b1);
			model_open[bank] = 1'b1;
			model_row[bank]  = row;
		end
		expect_cmd(wr ? cmd_write : cmd_read, 13'(col), 13'h1fff, bank, 1'b1);
		assert (rd == obs_cmd.size())
		else
			stop_with_error($sformatf("unexpected extra commands on the pins before %0t", $time));
	endtask

	always @(posedge CLK_n)
	begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit)
			stop_with_error($sformatf("timeout after %0d cycles, the DUT stopped responding",
				cycle));
	end

	// pin monitor, sampled mid-cycle
	always @(negedge CLK_n)
	begin
		if (RST)
		begin
			assert (cke || cmd_pin == cmd_nop)
			else
				stop_with_error($sformatf("[ERROR] %0t cmd_pin: expected NOP while cke low, got %s",
					$time, cmd_pin.name()));
			if (cmd_pin != cmd_nop)
			begin
				obs_cmd.push_back(cmd_pin);
				obs_addr.push_back(addr_pin);
				obs_bank.push_back(bank_pin);
				obs_time.push_back($time);
				obs_cycle.push_back(cycle);
			end
			if (ack)
			begin
				assert (user_ready)
				else
					stop_with_error($sformatf("ack pulsed before user_ready at %0t", $time));
				assert (cmd_pin == cmd_read || cmd_pin == cmd_write)
				else
					stop_with_error($sformatf("[ERROR] %0t cmd_pin: expected READ or WRITE with ack, got %s",
						$time, cmd_pin.name()));
				ack_count++;
			end
			if (user_ready && !ready_seen)
			begin
				ready_seen = 1'b1;
				check_init_table();
			end
		end
	end

	initial
	begin
		logic [35:0] p;
		int          gap_max;
		int          init_len;
		int          req_cost;
		int          refresh_cost;
		RST           = 1'b0;
		req           = 1'b0;
		we            = 1'b0;
		addr          = '0;
		cycle         = 0;
		limit         = 0;
		rd            = 0;
		ack_count     = 0;
		refresh_count = 0;
		pre_all_count = 0;
		ready_seen    = 1'b0;
		model_open    = '0;
		$readmemh("testbench/sdram_patterns.mem", patterns);
		assert (!$isunknown(patterns[num_pat-1]))
		else
			stop_with_error("pattern file testbench/sdram_patterns.mem could not be read");
		gap_max = 0;
		for (int i = 0; i < num_pat; i++)
			if (patterns[i][7:0] > gap_max)
				gap_max = patterns[i][7:0];
		init_len     = 8 + power_wait + 7 * (cmd_gap + 1) + settle_wait + 2;
		req_cost     = 6 + t_rp + t_rcd + gap_max;
		refresh_cost = 3 + t_rp + t_rfc;
		limit        = (init_len + num_pat * (req_cost + refresh_cost)) * 2;
		repeat (8) @(posedge CLK_n);
		RST <= 1'b1;
		for (int i = 0; i < num_pat; i++)
		begin
			p = patterns[i];
			repeat (p[7:0]) @(posedge CLK_n);
			if (i == 0)
				assert (!user_ready)
				else
					stop_with_error("first request was not raised ahead of user_ready");
			req  <= 1'b1;
			we   <= p[32];
			addr <= p[31:8];
			@(posedge CLK_n);
			while (!ack)
				@(posedge CLK_n);
			req <= 1'b0;
			check_request(p[32], p[31:8]);
		end
		repeat (4) @(posedge CLK_n);
		assert (ack_count == num_pat)
		else
			stop_with_error($sformatf("[ERROR] %0t ack: expected %0d pulses, got %0d",
				$time, num_pat, ack_count));
		assert (refresh_count > 0)
		else
			stop_with_error("no auto refresh appeared between the requests");
		assert (pre_all_count > 0)
		else
			stop_with_error("no precharge of all banks appeared ahead of a refresh");
		$display("All tests passed!");
		$finish;
	end

endmodule
